/* Bender.yml */
package:
  name: bch_loop

sources:
  - hw/bch_pkg.sv
  - hw/bch_stream_if.sv
  - hw/bch_encoder.sv
  - hw/bch_syndrome.sv
  - hw/bch_key_solver.sv
  - hw/bch_chien.sv
  - hw/bch_decoder.sv
  - hw/bch_channel_monitor.sv
  - hw/bch_loop.sv
  - target: test
    files:
      - tests/tb_bch_loop.sv

/* bch_loop.f */
hw/bch_pkg.sv
hw/bch_stream_if.sv
hw/bch_encoder.sv
hw/bch_syndrome.sv
hw/bch_key_solver.sv
hw/bch_chien.sv
hw/bch_decoder.sv
hw/bch_channel_monitor.sv
hw/bch_loop.sv
tests/tb_bch_loop.sv

/* hw/bch_channel_monitor.sv */
`default_nettype none

module bch_channel_monitor (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [bch_pkg::code_k-1:0] data_in,
	input wire logic [bch_pkg::code_n-1:0] error,
	bch_stream_if.sink enc,
	bch_stream_if.source chan,
	input wire logic output_valid,
	input wire logic decoded,
	output logic wrong_now,
	output logic wrong,
	output logic [bch_pkg::code_k-1:0] data_out
);

	logic [bch_pkg::code_n-1:0] flip_buf;
	logic [3:0][bch_pkg::code_k-1:0] ref_fifo;
	logic [1:0] wr_ptr;
	logic [1:0] rd_ptr;
	logic [2:0] out_bit;
	logic ref_bit;
	logic mismatch;
	logic block_end;

	assign chan.data = enc.data ^ flip_buf[0];
	assign chan.valid = enc.valid;
	assign chan.first = enc.first;
	assign chan.last = enc.last;

	assign ref_bit = ref_fifo[rd_ptr][out_bit];
	assign mismatch = output_valid && decoded != ref_bit;
	assign block_end = output_valid && out_bit == 3'(bch_pkg::code_k - 1);

	always_ff @(posedge clk) begin
		if (start)
			flip_buf <= error;
		else if (enc.valid)
			flip_buf <= flip_buf >> 1; // stays in step with the coded bits.
		if (start)
			ref_fifo[wr_ptr] <= data_in;
		if (output_valid)
			data_out <= {decoded, data_out[bch_pkg::code_k-1:1]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			out_bit <= '0;
			wrong_now <= 1'b0;
			wrong <= 1'b0;
		end else begin
			if (start)
				wr_ptr <= wr_ptr + 2'd1;
			if (block_end) begin
				rd_ptr <= rd_ptr + 2'd1;
				out_bit <= '0;
			end else if (output_valid) begin
				out_bit <= out_bit + 3'd1;
			end
			wrong_now <= mismatch;
			if (mismatch)
				wrong <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/bch_chien.sv */
`default_nettype none

module bch_chien (
	input wire logic clk,
	input wire logic reset,
	input wire bch_pkg::locator_t locator,
	input wire logic [1:0] loc_degree,
	input wire logic loc_valid,
	input wire logic [bch_pkg::code_n-1:0] word,
	output logic busy,
	output logic output_valid,
	output logic data_out
);

	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_emit
	} state_t;

	state_t state;
	bch_pkg::locator_t terms;
	bch_pkg::gf_t sum;
	logic [3:0] pos;
	logic [3:0] roots;
	logic [1:0] degree;
	logic [bch_pkg::code_k-1:0] flip;
	logic [bch_pkg::code_n-1:0] word_q;
	logic accept;
	logic fix;

	assign accept = loc_valid && state == st_idle;
	assign busy = state != st_idle;
	assign output_valid = state == st_emit;
	assign fix = roots == {2'b00, degree}; // root count must match the degree.
	assign data_out = word_q[0] ^ (fix && flip[0]);

	always_comb begin
		sum = '0;
		for (int j = 0; j <= bch_pkg::code_t; j++)
			sum = sum ^ terms[j];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (accept)
						state <= st_scan;
				st_scan:
					if (pos == 4'(bch_pkg::code_n - 1))
						state <= st_emit;
				st_emit:
					if (pos == 4'(bch_pkg::code_k - 1))
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int j = 0; j <= bch_pkg::code_t; j++)
				terms[j] <= bch_pkg::gf_mul(locator[j], bch_pkg::gf_alpha_pow(j));
			word_q <= word;
			degree <= loc_degree;
			roots <= '0;
			flip <= '0;
			pos <= '0;
		end else if (state == st_scan) begin
			// position i is a root when the locator vanishes at alpha^(i+1).
			for (int j = 0; j <= bch_pkg::code_t; j++)
				terms[j] <= bch_pkg::gf_mul(terms[j], bch_pkg::gf_alpha_pow(j));
			if (sum == '0) begin
				roots <= roots + 4'd1;
				if (pos < 4'(bch_pkg::code_k))
					flip[pos[2:0]] <= 1'b1;
			end
			pos <= pos == 4'(bch_pkg::code_n - 1) ? 4'd0 : pos + 4'd1;
		end else if (state == st_emit) begin
			word_q <= word_q >> 1;
			flip <= flip >> 1;
			pos <= pos + 4'd1;
		end
	end

endmodule

`default_nettype wire

/* hw/bch_decoder.sv */
`default_nettype none

module bch_decoder (
	input wire logic clk,
	input wire logic reset,
	bch_stream_if.sink stream,
	output logic can_accept,
	output logic output_valid,
	output logic data_out
);

	bch_pkg::syndrome_t syn;
	logic syn_valid;
	logic take;
	bch_pkg::locator_t locator;
	logic [1:0] loc_degree;
	logic loc_valid;
	logic chien_busy;
	logic chien_busy_q;
	logic [1:0][bch_pkg::code_n-1:0] word_buf;
	logic wr_slot;
	logic rd_slot;
	logic [1:0] in_flight;
	logic word_in;
	logic word_out;

	assign word_in = stream.valid && stream.first;
	assign word_out = chien_busy_q && !chien_busy;
	assign can_accept = in_flight < 2'd2;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_slot <= 1'b0;
			rd_slot <= 1'b0;
			in_flight <= '0;
			chien_busy_q <= 1'b0;
		end else begin
			chien_busy_q <= chien_busy;
			if (stream.valid && stream.last)
				wr_slot <= !wr_slot;
			if (loc_valid && !chien_busy)
				rd_slot <= !rd_slot; // follows the solver to chien handoff.
			in_flight <= in_flight + 2'(word_in) - 2'(word_out);
		end
	end

	always_ff @(posedge clk) begin
		if (stream.valid)
			word_buf[wr_slot] <= {stream.data, word_buf[wr_slot][bch_pkg::code_n-1:1]};
	end

	bch_syndrome bch_syndrome_inst (
		.clk(clk),
		.reset(reset),
		.stream(stream),
		.take(take),
		.syn(syn),
		.syn_valid(syn_valid)
	);

	bch_key_solver bch_key_solver_inst (
		.clk(clk),
		.reset(reset),
		.syn(syn),
		.syn_valid(syn_valid),
		.take(take),
		.busy_next(chien_busy),
		.locator(locator),
		.loc_degree(loc_degree),
		.loc_valid(loc_valid)
	);

	bch_chien bch_chien_inst (
		.clk(clk),
		.reset(reset),
		.locator(locator),
		.loc_degree(loc_degree),
		.loc_valid(loc_valid),
		.word(word_buf[rd_slot]),
		.busy(chien_busy),
		.output_valid(output_valid),
		.data_out(data_out)
	);

endmodule

`default_nettype wire

/* hw/bch_encoder.sv */
`default_nettype none

module bch_encoder (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire logic [bch_pkg::code_k-1:0] data_in,
	output logic penult,
	bch_stream_if.source stream
);

	localparam int par_w = bch_pkg::code_n - bch_pkg::code_k;

	logic busy;
	logic [3:0] count;
	logic [bch_pkg::code_k-1:0] msg;
	logic [par_w-1:0] lfsr;
	logic in_msg;
	logic feedback;

	assign in_msg = count < 4'(bch_pkg::code_k);
	assign feedback = msg[0] ^ lfsr[par_w-1];

	assign stream.data = in_msg ? msg[0] : lfsr[par_w-1];
	assign stream.valid = busy;
	assign stream.first = busy && count == 4'd0;
	assign stream.last = busy && count == 4'(bch_pkg::code_n - 1);
	assign penult = busy && count == 4'(bch_pkg::code_n - 2);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			count <= '0;
		end else if (busy) begin
			busy <= !stream.last;
			count <= count + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			msg <= data_in;
			lfsr <= '0;
		end else if (busy && in_msg) begin
			msg <= msg >> 1;
			lfsr <= {lfsr[par_w-2:0], 1'b0} ^ (feedback ? bch_pkg::gen_poly[par_w-1:0] : '0);
		end else if (busy) begin
			lfsr <= {lfsr[par_w-2:0], 1'b0}; // parity drains msb first.
		end
	end

endmodule

`default_nettype wire

/* hw/bch_key_solver.sv */
`default_nettype none

module bch_key_solver (
	input wire logic clk,
	input wire logic reset,
	input wire bch_pkg::syndrome_t syn,
	input wire logic syn_valid,
	output logic take,
	input wire logic busy_next,
	output bch_pkg::locator_t locator,
	output logic [1:0] loc_degree,
	output logic loc_valid
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_done
	} state_t;

	state_t state;
	bch_pkg::syndrome_t syn_q;
	bch_pkg::locator_t lambda;
	bch_pkg::locator_t b_poly;
	bch_pkg::locator_t lambda_next;
	bch_pkg::gf_t gamma;
	bch_pkg::gf_t delta;
	logic [2:0] len;
	logic [1:0] step;
	logic [2:0] k;
	logic grow;

	assign take = syn_valid && state == st_idle;
	assign loc_valid = state == st_done;
	assign k = {step, 1'b0}; // only even BM steps are computed.
	assign grow = delta != '0 && {len, 1'b0} <= {1'b0, k};

	// a locator longer than t cannot be right, so a zero polynomial marks failure.
	assign locator = len > 3'(bch_pkg::code_t) ? '0 : lambda;
	assign loc_degree = len[1:0];

	always_comb begin
		delta = '0;
		for (int j = 0; j <= bch_pkg::code_t; j++) begin
			if (int'(k) - j >= 0)
				delta = delta ^ bch_pkg::gf_mul(lambda[j], syn_q[int'(k) - j]);
		end
	end

	always_comb begin
		lambda_next[0] = bch_pkg::gf_mul(gamma, lambda[0]);
		for (int j = 1; j <= bch_pkg::code_t; j++)
			lambda_next[j] = bch_pkg::gf_mul(gamma, lambda[j])
				^ bch_pkg::gf_mul(delta, b_poly[j-1]);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (take)
						state <= st_run;
				st_run:
					if (step == 2'(bch_pkg::code_t - 1))
						state <= st_done;
				st_done:
					if (!busy_next)
						state <= st_idle; // chien takes it this cycle.
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			syn_q <= syn;
			lambda <= bch_pkg::locator_t'(1);
			b_poly <= bch_pkg::locator_t'(1);
			gamma <= bch_pkg::gf_t'(1);
			len <= '0;
			step <= '0;
		end else if (state == st_run) begin
			lambda <= lambda_next;
			step <= step + 2'd1;
			if (grow) begin
				b_poly <= {lambda[bch_pkg::code_t-1:0], bch_pkg::gf_t'(0)};
				len <= k + 3'd1 - len;
				gamma <= delta;
			end else begin
				b_poly <= {b_poly[bch_pkg::code_t-2:0], bch_pkg::gf_t'(0), bch_pkg::gf_t'(0)};
			end
		end
	end

endmodule

`default_nettype wire

/* hw/bch_loop.sv */
`default_nettype none

module bch_loop (
	input wire logic clk,
	input wire logic reset,
	input wire logic [bch_pkg::code_k-1:0] data_in,
	input wire logic [bch_pkg::code_n-1:0] error,
	input wire logic encode_start,
	output logic ready,
	output logic encoded_penult,
	output logic output_valid,
	output logic wrong_now,
	output logic wrong,
	output logic [bch_pkg::code_k-1:0] data_out
);

	bch_stream_if enc_stream ();
	bch_stream_if chan_stream ();

	logic start;
	logic can_accept;
	logic decoded;

	// the encoder frees up on its last bit, so words can run back to back.
	assign ready = (!enc_stream.valid || enc_stream.last) && can_accept;
	assign start = encode_start && ready;

	bch_encoder bch_encoder_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.penult(encoded_penult),
		.stream(enc_stream.source)
	);

	bch_channel_monitor bch_channel_monitor_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.data_in(data_in),
		.error(error),
		.enc(enc_stream.sink),
		.chan(chan_stream.source),
		.output_valid(output_valid),
		.decoded(decoded),
		.wrong_now(wrong_now),
		.wrong(wrong),
		.data_out(data_out)
	);

	bch_decoder bch_decoder_inst (
		.clk(clk),
		.reset(reset),
		.stream(chan_stream.sink),
		.can_accept(can_accept),
		.output_valid(output_valid),
		.data_out(decoded)
	);

endmodule

`default_nettype wire

/* hw/bch_pkg.sv */
`default_nettype none

package bch_pkg;

	localparam int code_n = 15;
	localparam int code_k = 5;
	localparam int code_t = 3;
	localparam int gf_m = 4;

	// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1.
	localparam logic [10:0] gen_poly = 11'b101_0011_0111;
	localparam logic [4:0] prim_poly = 5'b1_0011;

	typedef logic [gf_m-1:0] gf_t;
	typedef gf_t [code_t:0] locator_t;
	typedef gf_t [2*code_t-1:0] syndrome_t;

	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t prod;
		gf_t shifted;
		prod = '0;
		shifted = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				prod = prod ^ shifted;
			shifted = {shifted[gf_m-2:0], 1'b0} ^ (shifted[gf_m-1] ? prim_poly[gf_m-1:0] : '0);
		end
		return prod;
	endfunction

	function automatic gf_t gf_alpha_pow(int power);
		gf_t result;
		result = gf_t'(1);
		for (int i = 0; i < power % code_n; i++)
			result = gf_mul(result, gf_t'(2)); // alpha is x.
		return result;
	endfunction

endpackage

`default_nettype wire

/* hw/bch_stream_if.sv */
`default_nettype none

interface bch_stream_if;

	logic data; // codeword bit i sits at degree 14 - i.
	logic valid;
	logic first;
	logic last;

	modport source (
		output data, valid, first, last
	);

	modport sink (
		input data, valid, first, last
	);

endinterface

`default_nettype wire

/* hw/bch_syndrome.sv */
`default_nettype none

module bch_syndrome (
	input wire logic clk,
	input wire logic reset,
	bch_stream_if.sink stream,
	input wire logic take,
	output bch_pkg::syndrome_t syn,
	output logic syn_valid
);

	bch_pkg::gf_t acc1;
	bch_pkg::gf_t acc3;
	bch_pkg::gf_t acc5;
	bch_pkg::gf_t next1;
	bch_pkg::gf_t next3;
	bch_pkg::gf_t next5;
	bch_pkg::gf_t in_bit;

	assign in_bit = bch_pkg::gf_t'(stream.data);

	// one Horner step per received bit with the highest degree first.
	always_comb begin
		if (stream.first) begin
			next1 = in_bit;
			next3 = in_bit;
			next5 = in_bit;
		end else begin
			next1 = bch_pkg::gf_mul(acc1, bch_pkg::gf_alpha_pow(1)) ^ in_bit;
			next3 = bch_pkg::gf_mul(acc3, bch_pkg::gf_alpha_pow(3)) ^ in_bit;
			next5 = bch_pkg::gf_mul(acc5, bch_pkg::gf_alpha_pow(5)) ^ in_bit;
		end
	end

	always_ff @(posedge clk) begin
		if (stream.valid) begin
			acc1 <= next1;
			acc3 <= next3;
			acc5 <= next5;
		end
		if (stream.valid && stream.last) begin
			syn[0] <= next1;
			syn[1] <= bch_pkg::gf_mul(next1, next1);
			syn[2] <= next3;
			syn[3] <= bch_pkg::gf_mul(bch_pkg::gf_mul(next1, next1),
				bch_pkg::gf_mul(next1, next1));
			syn[4] <= next5;
			syn[5] <= bch_pkg::gf_mul(next3, next3);
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			syn_valid <= 1'b0;
		else if (stream.valid && stream.last)
			syn_valid <= 1'b1;
		else if (take)
			syn_valid <= 1'b0;
	end

endmodule

`default_nettype wire

/* tests/tb_bch_loop.sv */
`default_nettype none

module tb_bch_loop;

	localparam logic [31:0] rand_seed = 32'hfa13_8305;
	localparam int reset_cycles = 8;
	localparam int trial_cycles = 60;
	localparam int free_trials = 20;
	localparam int fix_trials = 40;
	localparam int burst_trials = 40;
	localparam int bad_trials = 30;
	localparam int reset_trials = 11;
	localparam int total_trials = free_trials + fix_trials + burst_trials + bad_trials
		+ reset_trials;
	localparam int cycle_limit = total_trials * trial_cycles + 2 * reset_cycles;

	logic clk;
	logic reset;
	logic [bch_pkg::code_k-1:0] data_in;
	logic [bch_pkg::code_n-1:0] error;
	logic encode_start;
	logic ready;
	logic encoded_penult;
	logic output_valid;
	logic wrong_now;
	logic wrong;
	logic [bch_pkg::code_k-1:0] data_out;

	logic [4:0] msg_q[$];
	logic [14:0] err_q[$];
	int phase_q[$];
	int bit_count;
	logic check_pending;
	logic saw_wrong;
	int cycles;

	bch_loop bch_loop_inst (
		.clk(clk),
		.reset(reset),
		.data_in(data_in),
		.error(error),
		.encode_start(encode_start),
		.ready(ready),
		.encoded_penult(encoded_penult),
		.output_valid(output_valid),
		.wrong_now(wrong_now),
		.wrong(wrong),
		.data_out(data_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string reason);
		$display("ERROR: %s", reason);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %0h, actual %0h", test, what, expected, actual);
			$display("** FAIL **");
			$fatal(1, "check failed");
		end
	endtask

	function automatic string phase_name(input int phase);
		case (phase)
			1: return "error_free";
			2: return "correctable";
			3: return "back_to_back";
			4: return "uncorrectable";
			default: return "after_reset";
		endcase
	endfunction

	function automatic int count_ones(input logic [14:0] value);
		int total;
		total = 0;
		for (int i = 0; i < 15; i++)
			total += value[i];
		return total;
	endfunction

	function automatic logic [10:0] poly_mul(input logic [10:0] a, input logic [10:0] b);
		logic [10:0] prod;
		prod = '0;
		for (int i = 0; i < 11; i++)
			if (b[i])
				prod = prod ^ (a << i);
		return prod;
	endfunction

	// codeword bit i is the coefficient of x^(14-i) and the message bits come first.
	function automatic logic [14:0] encode_word(input logic [4:0] msg);
		logic [10:0] gen;
		logic [14:0] rem;
		logic [14:0] word;
		gen = poly_mul(poly_mul(11'h013, 11'h01f), 11'h007); // minimal polys of alpha, alpha^3, alpha^5.
		rem = '0;
		for (int j = 0; j < 5; j++)
			rem[14 - j] = msg[j];
		for (int d = 14; d >= 10; d--)
			if (rem[d])
				rem = rem ^ (15'(gen) << (d - 10));
		for (int i = 0; i < 15; i++)
			word[i] = i < 5 ? msg[i] : rem[14 - i];
		return word;
	endfunction

	// bit 5 says whether some codeword lies within three bits of the word.
	function automatic logic [5:0] nearest_message(input logic [14:0] received);
		logic [5:0] result;
		result = '0;
		for (int m = 0; m < 32; m++)
			if (count_ones(encode_word(5'(m)) ^ received) <= 3)
				result = {1'b1, 5'(m)};
		return result;
	endfunction

	function automatic logic [14:0] pick_error(input int weight, input logic need_msg);
		logic [14:0] pattern;
		pattern = '0;
		if (need_msg)
			pattern[$urandom_range(4, 0)] = 1'b1;
		while (count_ones(pattern) < weight)
			pattern[$urandom_range(14, 0)] = 1'b1;
		return pattern;
	endfunction

	task automatic finish_block();
		logic [4:0] msg;
		logic [14:0] err;
		logic [5:0] model;
		int phase;
		string name;
		msg = msg_q.pop_front();
		err = err_q.pop_front();
		phase = phase_q.pop_front();
		name = phase_name(phase);
		model = nearest_message(encode_word(msg) ^ err);
		if (phase == 4) begin
			if (model[5])
				check_value(name, "data_out after miscorrection", model[4:0], data_out);
			check_value(name, "wrong_now pulse", 1, saw_wrong);
			check_value(name, "wrong", 1, wrong);
		end else begin
			check_value(name, "data_out", model[4:0], data_out);
			check_value(name, "wrong_now", 0, saw_wrong);
			check_value(name, "wrong", 0, wrong);
		end
	endtask

	task automatic check_reset_state(input string test);
		check_value(test, "ready", 1, ready);
		check_value(test, "wrong", 0, wrong);
		check_value(test, "output_valid", 0, output_valid);
		check_value(test, "encoded_penult", 0, encoded_penult);
		check_value(test, "wrong_now", 0, wrong_now);
	endtask

	task automatic issue_starts(input int phase, input int trials, input int min_w,
		input int max_w);
		int accepted;
		logic go;
		accepted = 0;
		while (accepted < trials) begin
			@(posedge clk);
			if (encode_start && ready) begin
				msg_q.push_back(data_in);
				err_q.push_back(error);
				phase_q.push_back(phase);
				accepted++;
			end
			if (phase == 3)
				go = encoded_penult || $urandom_range(3, 0) == 0; // penult lets words run back to back.
			else
				go = $urandom_range(5, 0) == 0;
			if (accepted < trials && go) begin
				encode_start <= 1'b1;
				data_in <= 5'($urandom_range(31, 0));
				error <= pick_error($urandom_range(max_w, min_w), phase == 4);
			end else begin
				encode_start <= 1'b0;
			end
		end
	endtask

	task automatic drain_outputs();
		while (msg_q.size() != 0)
			@(posedge clk);
		repeat (25) @(posedge clk); // a stray block here finds no queued word.
	endtask

	always @(posedge clk) begin
		if (reset) begin
			bit_count = 0;
			check_pending = 1'b0;
		end else begin
			if (check_pending) begin
				saw_wrong = saw_wrong | wrong_now; // mismatch of the last bit.
				check_pending = 1'b0;
				finish_block();
			end
			if (output_valid) begin
				if (bit_count == 0) begin
					saw_wrong = 1'b0;
					if (msg_q.size() == 0)
						stop_run("output_valid rose with no accepted word in flight");
				end
				saw_wrong = saw_wrong | wrong_now;
				bit_count = bit_count + 1;
				if (bit_count == bch_pkg::code_k) begin
					bit_count = 0;
					check_pending = 1'b1;
				end
			end else if (bit_count != 0) begin
				stop_run("output_valid dropped in the middle of a message block");
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit)
			stop_run("timeout, the decoded words stopped arriving");
	end

	initial begin
		reset = 1'b1;
		encode_start = 1'b0;
		data_in = '0;
		error = '0;
		bit_count = 0;
		check_pending = 1'b0;
		saw_wrong = 1'b0;
		cycles = 0;
		void'($urandom(rand_seed));
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_reset_state("power_on");
		issue_starts(1, free_trials, 0, 0);
		drain_outputs();
		issue_starts(2, fix_trials, 1, 3);
		drain_outputs();
		issue_starts(3, burst_trials, 0, 3);
		drain_outputs();
		issue_starts(4, bad_trials, 4, 6);
		drain_outputs();
		issue_starts(5, 1, 0, 3);
		repeat (20) @(posedge clk); // the word is inside the decoder now.
		reset <= 1'b1;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
		msg_q.delete();
		err_q.delete();
		phase_q.delete();
		@(posedge clk);
		check_reset_state("after_reset");
		repeat (20) @(posedge clk);
		issue_starts(5, reset_trials - 1, 0, 3);
		drain_outputs();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
